// File: rtl/core_pkg.sv
package core_pkg;

    ////////////////////////////////////////
    // data widths

    typedef logic [7:0]  byte_t;
    typedef logic [15:0] addr_t;

    ////////////////////////////////////////
    // control encodings

    typedef enum logic {
        FETCH,
        EXEC
    } seq_state_t;

    // doubles as the microcode entry
    typedef enum logic [2:0] {
        IMM_ALU,
        IMPLIED,
        STORE_ZP,
        JMP_ABS,
        BRANCH
    } instr_class_t;

    typedef enum logic [2:0] {
        HOLD,
        PASS,
        ADD,
        AND_OP,
        OR_OP,
        XOR_OP
    } alu_op_t;

    typedef enum logic [1:0] {
        DEST_A,
        DEST_X,
        DEST_Y,
        DEST_NONE
    } dest_t;

    // store source
    typedef enum logic [1:0] {
        REG_A,
        REG_X,
        REG_Y
    } reg_sel_t;

    typedef enum logic [1:0] {
        COND_C,
        COND_Z,
        COND_N,
        COND_V
    } branch_cond_t;

    typedef enum logic {
        ADDR_PC,
        ADDR_ZERO_PAGE
    } addr_src_t;

    typedef enum logic [1:0] {
        PC_NONE,
        PC_ABS,
        PC_REL
    } pc_load_t;

endpackage : core_pkg

// File: rtl/instr_decode.sv
module instr_decode (
    input  core_pkg::byte_t        i_opcode,
    output core_pkg::instr_class_t o_class,
    output core_pkg::alu_op_t      o_alu_op,
    output logic                   o_src2_inv,
    output logic                   o_carry_force,
    output core_pkg::dest_t        o_dest,
    output core_pkg::reg_sel_t     o_store_sel,
    output logic                   o_set_c,
    output logic                   o_clr_c,
    output core_pkg::branch_cond_t o_branch_cond,
    output logic                   o_branch_inv
);
    import core_pkg::*;

    always_comb begin
        // anything unlisted behaves as NOP
        o_class       = IMPLIED;
        o_alu_op      = HOLD;
        o_src2_inv    = 1'b0;
        o_carry_force = 1'b0;
        o_dest        = DEST_NONE;
        o_store_sel   = REG_A;
        o_set_c       = 1'b0;
        o_clr_c       = 1'b0;
        o_branch_cond = COND_C;
        o_branch_inv  = 1'b0;

        // branches are xxy10000: xx picks the flag, y the value that takes it
        if (i_opcode[4:0] == 5'b10000) begin
            o_class      = BRANCH;
            o_branch_inv = ~i_opcode[5];
            case (i_opcode[7:6])
                2'b00:   o_branch_cond = COND_N;
                2'b01:   o_branch_cond = COND_V;
                2'b10:   o_branch_cond = COND_C;
                default: o_branch_cond = COND_Z;
            endcase
        end else begin
            case (i_opcode)
                8'hA9, 8'hA2, 8'hA0: begin
                    o_class  = IMM_ALU;
                    o_alu_op = PASS;
                    o_dest   = (i_opcode == 8'hA9) ? DEST_A :
                               (i_opcode == 8'hA2) ? DEST_X : DEST_Y;
                end
                8'h69, 8'hE9, 8'hC9: begin
                    o_class       = IMM_ALU;
                    o_alu_op      = ADD;
                    o_src2_inv    = (i_opcode != 8'h69);
                    o_carry_force = (i_opcode == 8'hC9);
                    o_dest        = (i_opcode == 8'hC9) ? DEST_NONE : DEST_A;
                end
                8'h29, 8'h09, 8'h49: begin
                    o_class  = IMM_ALU;
                    o_dest   = DEST_A;
                    o_alu_op = (i_opcode == 8'h29) ? AND_OP :
                               (i_opcode == 8'h09) ? OR_OP : XOR_OP;
                end
                8'h18: o_clr_c = 1'b1;
                8'h38: o_set_c = 1'b1;
                8'h85, 8'h86, 8'h84: begin
                    o_class     = STORE_ZP;
                    o_store_sel = (i_opcode == 8'h85) ? REG_A :
                                  (i_opcode == 8'h86) ? REG_X : REG_Y;
                end
                8'h4C: o_class = JMP_ABS;
                default: ;
            endcase
        end
    end

endmodule : instr_decode

// File: rtl/ucode_sequencer.sv
module ucode_sequencer (
    input  logic                   i_clock,
    input  logic                   i_reset,
    input  core_pkg::instr_class_t i_class,
    input  core_pkg::branch_cond_t i_branch_cond,
    input  logic                   i_branch_inv,
    input  logic                   i_n,
    input  logic                   i_v,
    input  logic                   i_z,
    input  logic                   i_c,
    output core_pkg::seq_state_t   o_state,
    output core_pkg::addr_src_t    o_addr_src,
    output logic                   o_mem_rd,
    output logic                   o_mem_wr,
    output logic                   o_inc_pc,
    output logic                   o_buf_load,
    output logic                   o_alu_go,
    output logic                   o_writeback,
    output core_pkg::pc_load_t     o_pc_load
);
    import core_pkg::*;

    seq_state_t state_q;
    logic [1:0] step_q;
    logic       branch_bit;
    logic       uop_rd;
    logic       done;

    always_comb begin
        case (i_branch_cond)
            COND_C:  branch_bit = i_c ^ i_branch_inv;
            COND_Z:  branch_bit = i_z ^ i_branch_inv;
            COND_N:  branch_bit = i_n ^ i_branch_inv;
            default: branch_bit = i_v ^ i_branch_inv;
        endcase
    end

    ////////////////////////////////////////
    // microcode, one row per class and step

    always_comb begin
        o_addr_src  = ADDR_PC;
        uop_rd      = 1'b0;
        o_mem_wr    = 1'b0;
        o_inc_pc    = 1'b0;
        o_buf_load  = 1'b0;
        o_alu_go    = 1'b0;
        o_writeback = 1'b0;
        o_pc_load   = PC_NONE;
        done        = 1'b1;

        if (state_q == FETCH) begin
            uop_rd   = 1'b1;
            o_inc_pc = 1'b1;
        end else if (step_q == 2'd0 && i_class != IMPLIED) begin
            // every multi-step class reads its operand byte first
            uop_rd     = 1'b1;
            o_inc_pc   = 1'b1;
            o_alu_go   = (i_class == IMM_ALU);
            o_buf_load = (i_class != IMM_ALU);
            done       = (i_class == BRANCH) && !branch_bit;
        end else begin
            case (i_class)
                IMPLIED, IMM_ALU: o_writeback = 1'b1;
                STORE_ZP: begin
                    o_addr_src = ADDR_ZERO_PAGE;
                    o_mem_wr   = 1'b1;
                end
                JMP_ABS: begin
                    uop_rd    = 1'b1;
                    o_pc_load = PC_ABS;
                end
                BRANCH:  o_pc_load = PC_REL;
                default: ;
            endcase
        end
    end

    // nothing reaches memory while the core is held
    assign o_mem_rd = uop_rd & ~i_reset;
    assign o_state  = state_q;

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            state_q <= FETCH;
            step_q  <= 2'd0;
        end else if (state_q == FETCH || done) begin
            state_q <= (state_q == FETCH) ? EXEC : FETCH;
            step_q  <= 2'd0;
        end else begin
            step_q <= step_q + 2'd1;
        end
    end

    a_rd_wr_exclusive: assert property (@(posedge i_clock) disable iff (i_reset)
        !(o_mem_rd && o_mem_wr));

    a_step_in_range: assert property (@(posedge i_clock) disable iff (i_reset)
        step_q <= 2'd1);

endmodule : ucode_sequencer

// File: rtl/alu.sv
module alu (
    input  logic              i_clock,
    input  logic              i_reset,
    input  core_pkg::alu_op_t i_op,
    input  core_pkg::byte_t   i_src1,
    input  core_pkg::byte_t   i_src2,
    input  logic              i_src2_inv,
    input  logic              i_c_in,
    output core_pkg::byte_t   o_out,
    output logic              o_n,
    output logic              o_v,
    output logic              o_z,
    output logic              o_c
);
    import core_pkg::*;

    byte_t      operand2;
    byte_t      result;
    logic [8:0] sum;
    logic       carry;
    logic       overflow;

    always_comb begin
        operand2 = i_src2_inv ? ~i_src2 : i_src2;
        sum      = {1'b0, i_src1} + {1'b0, operand2} + {8'h00, i_c_in};
        carry    = 1'b0;
        overflow = 1'b0;
        case (i_op)
            PASS:    result = i_src2;
            ADD: begin
                result   = sum[7:0];
                carry    = sum[8];
                // same sign in, other sign out
                overflow = (i_src1[7] == operand2[7]) && (sum[7] != i_src1[7]);
            end
            AND_OP:  result = i_src1 & i_src2;
            OR_OP:   result = i_src1 | i_src2;
            XOR_OP:  result = i_src1 ^ i_src2;
            default: result = 8'h00;
        endcase
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            o_out <= 8'h00;
            o_n   <= 1'b0;
            o_v   <= 1'b0;
            o_z   <= 1'b0;
            o_c   <= 1'b0;
        end else if (i_op != HOLD) begin
            o_out <= result;
            o_n   <= result[7];
            o_v   <= overflow;
            o_z   <= (result == 8'h00);
            o_c   <= carry;
        end
    end

    // writeback reads these one step after the op
    a_hold_stable: assert property (@(posedge i_clock) disable iff (i_reset)
        i_op == HOLD |=> $stable({o_out, o_n, o_v, o_z, o_c}));

endmodule : alu

// File: rtl/datapath_ctrl.sv
module datapath_ctrl (
    input  core_pkg::seq_state_t i_state,
    input  core_pkg::addr_src_t  i_addr_src,
    input  logic                 i_mem_rd,
    input  logic                 i_mem_wr,
    input  logic                 i_inc_pc,
    input  logic                 i_alu_go,
    input  logic                 i_writeback,
    input  core_pkg::pc_load_t   i_pc_load,
    input  core_pkg::alu_op_t    i_alu_op,
    input  logic                 i_carry_force,
    input  core_pkg::dest_t      i_dest,
    input  core_pkg::reg_sel_t   i_store_sel,
    input  logic                 i_set_c,
    input  logic                 i_clr_c,
    input  core_pkg::byte_t      i_a,
    input  core_pkg::byte_t      i_x,
    input  core_pkg::byte_t      i_y,
    input  logic                 i_c,
    input  core_pkg::addr_t      i_pc,
    input  core_pkg::byte_t      i_buf,
    input  core_pkg::byte_t      i_r_data,
    input  logic                 i_alu_c,
    output core_pkg::alu_op_t    o_alu_op,
    output core_pkg::byte_t      o_src1,
    output core_pkg::byte_t      o_src2,
    output logic                 o_c_in,
    output logic                 o_a_en,
    output logic                 o_x_en,
    output logic                 o_y_en,
    output logic                 o_flag_en_nz,
    output logic [1:0]           o_flag_en_cv,
    output logic                 o_c_next,
    output logic                 o_inc_pc,
    output core_pkg::pc_load_t   o_pc_load,
    output logic                 o_opcode_load,
    output core_pkg::addr_t      o_addr,
    output logic                 o_mem_r_en,
    output logic                 o_mem_w_en,
    output core_pkg::byte_t      o_w_data
);
    import core_pkg::*;

    logic alu_wb;
    logic arith;

    ////////////////////////////////////////
    // alu operands

    assign o_alu_op = i_alu_go ? i_alu_op : HOLD;
    assign o_src1   = (i_alu_op == PASS) ? 8'h00 : i_a;
    assign o_src2   = i_r_data;
    assign o_c_in   = i_carry_force | i_c;

    ////////////////////////////////////////
    // register and flag enables

    assign alu_wb = i_writeback && (i_alu_op != HOLD);
    assign arith  = (i_alu_op == ADD);

    assign o_a_en = i_writeback && (i_dest == DEST_A);
    assign o_x_en = i_writeback && (i_dest == DEST_X);
    assign o_y_en = i_writeback && (i_dest == DEST_Y);

    assign o_flag_en_nz = alu_wb;
    // bit 1 is C, bit 0 is V; CMP leaves V alone
    assign o_flag_en_cv = {i_writeback && (arith || i_set_c || i_clr_c),
                           alu_wb && arith && !i_carry_force};
    assign o_c_next     = i_set_c ? 1'b1 : (i_clr_c ? 1'b0 : i_alu_c);

    assign o_inc_pc      = i_inc_pc;
    assign o_pc_load     = i_pc_load;
    assign o_opcode_load = (i_state == FETCH);

    ////////////////////////////////////////
    // memory side

    assign o_addr     = (i_addr_src == ADDR_ZERO_PAGE) ? {8'h00, i_buf} : i_pc;
    assign o_mem_r_en = i_mem_rd;
    assign o_mem_w_en = i_mem_wr;

    always_comb begin
        case (i_store_sel)
            REG_X:   o_w_data = i_x;
            REG_Y:   o_w_data = i_y;
            default: o_w_data = i_a;
        endcase
    end

endmodule : datapath_ctrl

// File: rtl/arch_regs.sv
module arch_regs #(
    parameter core_pkg::addr_t RESET_PC = 16'h4020
) (
    input  logic               i_clock,
    input  logic               i_reset,
    input  logic               i_a_en,
    input  logic               i_x_en,
    input  logic               i_y_en,
    input  logic               i_flag_en_nz,
    input  logic [1:0]         i_flag_en_cv,
    input  logic               i_c_next,
    input  logic               i_inc_pc,
    input  core_pkg::pc_load_t i_pc_load,
    input  core_pkg::byte_t    i_alu_out,
    input  logic               i_alu_n,
    input  logic               i_alu_v,
    input  logic               i_alu_z,
    input  core_pkg::byte_t    i_r_data,
    input  logic               i_buf_load,
    input  logic               i_opcode_load,
    output core_pkg::byte_t    o_a,
    output core_pkg::byte_t    o_x,
    output core_pkg::byte_t    o_y,
    output logic               o_n,
    output logic               o_v,
    output logic               o_z,
    output logic               o_c,
    output core_pkg::addr_t    o_pc,
    output core_pkg::byte_t    o_buf,
    output core_pkg::byte_t    o_opcode
);
    import core_pkg::*;

    addr_t rel_offset;

    assign rel_offset = {{8{o_buf[7]}}, o_buf};

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            o_a      <= 8'h00;
            o_x      <= 8'h00;
            o_y      <= 8'h00;
            {o_n, o_v, o_z, o_c} <= 4'b0000;
            o_pc     <= RESET_PC;
            o_buf    <= 8'h00;
            o_opcode <= 8'h00;
        end else begin
            if (i_a_en) o_a <= i_alu_out;
            if (i_x_en) o_x <= i_alu_out;
            if (i_y_en) o_y <= i_alu_out;
            if (i_flag_en_nz) begin
                o_n <= i_alu_n;
                o_z <= i_alu_z;
            end
            if (i_flag_en_cv[1]) o_c <= i_c_next;
            if (i_flag_en_cv[0]) o_v <= i_alu_v;
            if (i_buf_load) o_buf <= i_r_data;
            if (i_opcode_load) o_opcode <= i_r_data;

            // low byte of an absolute target waits in the buffer
            if (i_inc_pc) begin
                o_pc <= o_pc + 16'd1;
            end else if (i_pc_load == PC_ABS) begin
                o_pc <= {i_r_data, o_buf};
            end else if (i_pc_load == PC_REL) begin
                o_pc <= o_pc + rel_offset;
            end
        end
    end

    a_pc_one_source: assert property (@(posedge i_clock) disable iff (i_reset)
        !(i_inc_pc && i_pc_load != PC_NONE));

endmodule : arch_regs

// File: rtl/core_top.sv
module core_top #(
    parameter core_pkg::addr_t RESET_PC = 16'h4020
) (
    input  logic            i_clock,
    input  logic            i_reset,
    output core_pkg::addr_t o_addr,
    output logic            o_mem_r_en,
    output logic            o_mem_w_en,
    output core_pkg::byte_t o_w_data,
    input  core_pkg::byte_t i_r_data
);
    import core_pkg::*;

    // decode
    byte_t        opcode;
    instr_class_t instr_class;
    alu_op_t      dec_alu_op;
    dest_t        dest;
    reg_sel_t     store_sel;
    branch_cond_t branch_cond;
    logic         src2_inv, carry_force, set_c, clr_c, branch_inv;

    // micro-op
    seq_state_t   state;
    addr_src_t    addr_src;
    pc_load_t     seq_pc_load, pc_load;
    logic         mem_rd, mem_wr, seq_inc_pc, inc_pc, buf_load, alu_go, writeback;

    // alu
    alu_op_t      alu_op;
    byte_t        src1, src2, alu_out;
    logic         c_in, alu_n, alu_v, alu_z, alu_c;

    // architectural state
    byte_t        a, x, y, buf_q;
    addr_t        pc;
    logic         n, v, z, c;
    logic         a_en, x_en, y_en, flag_en_nz, c_next, opcode_load;
    logic [1:0]   flag_en_cv;

    instr_decode u_instr_decode (
        .i_opcode(opcode), .o_class(instr_class), .o_alu_op(dec_alu_op),
        .o_src2_inv(src2_inv), .o_carry_force(carry_force), .o_dest(dest),
        .o_store_sel(store_sel), .o_set_c(set_c), .o_clr_c(clr_c),
        .o_branch_cond(branch_cond), .o_branch_inv(branch_inv));

    ucode_sequencer u_ucode_sequencer (
        .i_clock(i_clock), .i_reset(i_reset), .i_class(instr_class),
        .i_branch_cond(branch_cond), .i_branch_inv(branch_inv),
        .i_n(n), .i_v(v), .i_z(z), .i_c(c),
        .o_state(state), .o_addr_src(addr_src), .o_mem_rd(mem_rd), .o_mem_wr(mem_wr),
        .o_inc_pc(seq_inc_pc), .o_buf_load(buf_load), .o_alu_go(alu_go),
        .o_writeback(writeback), .o_pc_load(seq_pc_load));

    alu u_alu (
        .i_clock(i_clock), .i_reset(i_reset), .i_op(alu_op), .i_src1(src1),
        .i_src2(src2), .i_src2_inv(src2_inv), .i_c_in(c_in),
        .o_out(alu_out), .o_n(alu_n), .o_v(alu_v), .o_z(alu_z), .o_c(alu_c));

    datapath_ctrl u_datapath_ctrl (
        .i_state(state), .i_addr_src(addr_src), .i_mem_rd(mem_rd), .i_mem_wr(mem_wr),
        .i_inc_pc(seq_inc_pc), .i_alu_go(alu_go), .i_writeback(writeback),
        .i_pc_load(seq_pc_load), .i_alu_op(dec_alu_op), .i_carry_force(carry_force),
        .i_dest(dest), .i_store_sel(store_sel), .i_set_c(set_c), .i_clr_c(clr_c),
        .i_a(a), .i_x(x), .i_y(y), .i_c(c), .i_pc(pc), .i_buf(buf_q),
        .i_r_data(i_r_data), .i_alu_c(alu_c),
        .o_alu_op(alu_op), .o_src1(src1), .o_src2(src2), .o_c_in(c_in),
        .o_a_en(a_en), .o_x_en(x_en), .o_y_en(y_en), .o_flag_en_nz(flag_en_nz),
        .o_flag_en_cv(flag_en_cv), .o_c_next(c_next), .o_inc_pc(inc_pc),
        .o_pc_load(pc_load), .o_opcode_load(opcode_load), .o_addr(o_addr),
        .o_mem_r_en(o_mem_r_en), .o_mem_w_en(o_mem_w_en), .o_w_data(o_w_data));

    arch_regs #(.RESET_PC(RESET_PC)) u_arch_regs (
        .i_clock(i_clock), .i_reset(i_reset), .i_a_en(a_en), .i_x_en(x_en),
        .i_y_en(y_en), .i_flag_en_nz(flag_en_nz), .i_flag_en_cv(flag_en_cv),
        .i_c_next(c_next), .i_inc_pc(inc_pc), .i_pc_load(pc_load),
        .i_alu_out(alu_out), .i_alu_n(alu_n), .i_alu_v(alu_v), .i_alu_z(alu_z),
        .i_r_data(i_r_data), .i_buf_load(buf_load), .i_opcode_load(opcode_load),
        .o_a(a), .o_x(x), .o_y(y), .o_n(n), .o_v(v), .o_z(z), .o_c(c),
        .o_pc(pc), .o_buf(buf_q), .o_opcode(opcode));

endmodule : core_top

// File: tb/tb_memory.sv
module tb_memory (
    input  logic            i_clock,
    input  core_pkg::addr_t i_addr,
    input  logic            i_w_en,
    input  core_pkg::byte_t i_w_data,
    output core_pkg::byte_t o_r_data
);
    import core_pkg::*;

    byte_t mem [0:65535];

    // every write the core makes, oldest first
    addr_t wr_addr_q [$];
    byte_t wr_data_q [$];

    // asynchronous read
    assign o_r_data = mem[i_addr];

    // address and data are settled by the falling edge
    always @(negedge i_clock) begin
        if (i_w_en) begin
            wr_addr_q.push_back(i_addr);
            wr_data_q.push_back(i_w_data);
        end
    end

    // unused bytes get a value tied to their full address
    function automatic void fill_memory();
        int i;
        for (i = 0; i < 65536; i++) begin
            mem[i[15:0]] = byte_t'(i ^ (i >> 8));
        end
    endfunction

    function automatic void load_byte(addr_t addr, byte_t data);
        mem[addr] = data;
    endfunction

    function automatic int write_count();
        return wr_addr_q.size();
    endfunction

    function automatic addr_t write_addr_at(int idx);
        return wr_addr_q[idx];
    endfunction

    function automatic byte_t write_data_at(int idx);
        return wr_data_q[idx];
    endfunction

endmodule : tb_memory

// File: tb/tb_core.sv
module tb_core #(
    parameter core_pkg::addr_t RESET_PC = 16'h4020
);
    import core_pkg::*;

    localparam byte_t OP_LDA = 8'hA9;
    localparam byte_t OP_LDX = 8'hA2;
    localparam byte_t OP_LDY = 8'hA0;
    localparam byte_t OP_ADC = 8'h69;
    localparam byte_t OP_SBC = 8'hE9;
    localparam byte_t OP_AND = 8'h29;
    localparam byte_t OP_ORA = 8'h09;
    localparam byte_t OP_EOR = 8'h49;
    localparam byte_t OP_CMP = 8'hC9;
    localparam byte_t OP_CLC = 8'h18;
    localparam byte_t OP_SEC = 8'h38;
    localparam byte_t OP_STA = 8'h85;
    localparam byte_t OP_STX = 8'h86;
    localparam byte_t OP_STY = 8'h84;
    localparam byte_t OP_JMP = 8'h4C;
    localparam byte_t OP_BNE = 8'hD0;
    localparam byte_t OP_NOP = 8'hEA;

    logic  clock;
    logic  reset;
    addr_t addr;
    logic  mem_r_en;
    logic  mem_w_en;
    byte_t w_data;
    byte_t r_data;

    integer seed = 2;
    string  test_name;
    int     test_errors = 0;
    int     total_errors = 0;
    int     tests_run = 0;
    int     tests_failed = 0;
    int     program_bytes = 0;
    int     write_base = 0;
    addr_t  emit_pc;
    addr_t  end_addr;
    addr_t  exp_addr_q [$];
    byte_t  exp_data_q [$];

    core_top #(.RESET_PC(RESET_PC)) u_core_top (
        .i_clock(clock), .i_reset(reset), .o_addr(addr), .o_mem_r_en(mem_r_en),
        .o_mem_w_en(mem_w_en), .o_w_data(w_data), .i_r_data(r_data));

    tb_memory u_mem (
        .i_clock(clock), .i_addr(addr), .i_w_en(mem_w_en), .i_w_data(w_data),
        .o_r_data(r_data));

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    ////////////////////////////////////////
    // checks and program building

    task automatic check_value(string what, int expected, int actual);
        assert (expected == actual) else begin
            $display("** Error %s: %s expected %0h, actual %0h", test_name, what, expected,
                     actual);
            test_errors++;
        end
    endtask

    task automatic check_true(string what, logic cond);
        assert (cond) else begin
            $display("%s: %s", test_name, what);
            test_errors++;
        end
    endtask

    function automatic byte_t rand_byte();
        return byte_t'($random(seed));
    endfunction

    // 6502 branch rules, one opcode per flag and polarity
    function automatic logic branch_taken(byte_t op, logic n, logic v, logic z, logic c);
        case (op)
            8'h10:   return !n;
            8'h30:   return n;
            8'h50:   return !v;
            8'h70:   return v;
            8'h90:   return !c;
            8'hB0:   return c;
            8'hD0:   return !z;
            8'hF0:   return z;
            default: return 1'b0;
        endcase
    endfunction

    task automatic emit(byte_t b);
        u_mem.load_byte(emit_pc, b);
        emit_pc = emit_pc + 16'd1;
        program_bytes++;
    endtask

    task automatic emit_arg(byte_t op, byte_t arg);
        emit(op);
        emit(arg);
    endtask

    task automatic expect_write(byte_t zp, byte_t data);
        exp_addr_q.push_back({8'h00, zp});
        exp_data_q.push_back(data);
    endtask

    // core held in reset while the new image goes in
    task automatic begin_test(string name);
        test_name = name;
        test_errors = 0;
        @(posedge clock);
        #1 reset = 1'b1;
        @(posedge clock);
        #1;
        u_mem.fill_memory();
        write_base = u_mem.write_count();
        exp_addr_q.delete();
        exp_data_q.delete();
        emit_pc = RESET_PC;
    endtask

    task automatic run_program();
        int i;
        int count;
        end_addr = emit_pc;
        emit(OP_JMP);
        emit(end_addr[7:0]);
        emit(end_addr[15:8]);
        for (i = 0; i < 3; i++) begin
            @(negedge clock);
            check_true("memory strobe active during reset", !mem_r_en && !mem_w_en);
            @(posedge clock);
        end
        #1 reset = 1'b0;
        @(negedge clock);
        check_true("no opcode read in the first cycle after reset", mem_r_en && !mem_w_en);
        check_value("first address", int'(RESET_PC), int'(addr));
        // the final jump to itself marks the end
        while (!(mem_r_en && addr == end_addr)) begin
            @(negedge clock);
        end
        count = u_mem.write_count() - write_base;
        check_value("write count", exp_addr_q.size(), count);
        for (i = 0; i < exp_addr_q.size() && i < count; i++) begin
            check_value("write address", int'(exp_addr_q[i]),
                        int'(u_mem.write_addr_at(write_base + i)));
            check_value("write data", int'(exp_data_q[i]),
                        int'(u_mem.write_data_at(write_base + i)));
        end
        tests_run++;
        total_errors += test_errors;
        if (test_errors == 0) begin
            $display("test %s ok", test_name);
        end else begin
            tests_failed++;
            $display("test %s had %0d errors", test_name, test_errors);
        end
    endtask

    ////////////////////////////////////////
    // tests

    task automatic test_load_store();
        byte_t va, vx, vy;
        begin_test("load_store");
        va = rand_byte();
        vx = rand_byte();
        vy = rand_byte();
        emit_arg(OP_LDA, va);
        emit_arg(OP_LDX, vx);
        emit_arg(OP_LDY, vy);
        emit_arg(OP_STA, 8'h10);
        emit_arg(OP_STX, 8'h11);
        emit_arg(OP_STY, 8'h12);
        expect_write(8'h10, va);
        expect_write(8'h11, vx);
        expect_write(8'h12, vy);
        run_program();
    endtask

    task automatic test_arith();
        byte_t a, b;
        int    carry;
        begin_test("arithmetic");
        for (carry = 0; carry < 2; carry++) begin
            a = rand_byte();
            b = rand_byte();
            emit_arg(OP_LDA, a);
            emit(carry != 0 ? OP_SEC : OP_CLC);
            emit_arg(OP_ADC, b);
            emit_arg(OP_STA, 8'h20);
            expect_write(8'h20, byte_t'(int'(a) + int'(b) + carry));
            emit_arg(OP_LDA, a);
            emit(carry != 0 ? OP_SEC : OP_CLC);
            emit_arg(OP_SBC, b);
            emit_arg(OP_STA, 8'h21);
            expect_write(8'h21, byte_t'(int'(a) - int'(b) - (1 - carry)));
        end
        run_program();
    endtask

    task automatic test_logic();
        byte_t a, b;
        begin_test("logic");
        a = rand_byte();
        b = rand_byte();
        emit_arg(OP_LDA, a);
        emit_arg(OP_AND, b);
        emit_arg(OP_STA, 8'h30);
        emit_arg(OP_LDA, a);
        emit_arg(OP_ORA, b);
        emit_arg(OP_STA, 8'h31);
        emit_arg(OP_LDA, a);
        emit_arg(OP_EOR, b);
        emit_arg(OP_STA, 8'h32);
        expect_write(8'h30, a & b);
        expect_write(8'h31, a | b);
        expect_write(8'h32, a ^ b);
        run_program();
    endtask

    // Y is cleared, the flag is set up, and a taken branch skips LDY #1
    task automatic test_branches();
        byte_t      op, a, b, zp;
        int         signed_sum;
        logic       n, v, z, c;
        int         k, round;
        begin_test("branches");
        zp = 8'h40;
        for (k = 0; k < 8; k++) begin
            for (round = 0; round < 2; round++) begin
                op = byte_t'(16 + 32 * k);
                a = rand_byte();
                b = rand_byte();
                {n, v, z, c} = 4'b0000;
                emit_arg(OP_LDY, 8'h00);
                case (k / 2)
                    0: begin
                        a[7] = round[0];
                        emit_arg(OP_LDA, a);
                        n = a[7];
                    end
                    1: begin
                        // same signs overflow in round 1, mixed signs never do
                        a = (round != 0) ? (8'h40 | {2'b00, a[5:0]}) : {1'b0, a[6:0]};
                        b = (round != 0) ? (8'h40 | {2'b00, b[5:0]}) : {1'b1, b[6:0]};
                        emit(OP_CLC);
                        emit_arg(OP_LDA, a);
                        emit_arg(OP_ADC, b);
                        // true sum of the signed values, outside -128..127 overflows
                        signed_sum = int'($signed(a)) + int'($signed(b));
                        v = (signed_sum > 127) || (signed_sum < -128);
                    end
                    2: begin
                        a = {1'b0, a[6:0]};
                        b = (round != 0) ? (a & b) : (a + 8'd1 + {2'b00, b[5:0]});
                        emit_arg(OP_LDA, a);
                        emit_arg(OP_CMP, b);
                        c = (a >= b);
                    end
                    default: begin
                        if (round == 0) begin
                            a = b[0] ? 8'h00 : a;
                            emit_arg(OP_LDA, a);
                            z = (a == 8'h00);
                        end else begin
                            b = b[0] ? a : b;
                            emit_arg(OP_LDA, a);
                            emit_arg(OP_CMP, b);
                            z = (a == b);
                        end
                    end
                endcase
                emit_arg(op, 8'h02);
                emit_arg(OP_LDY, 8'h01);
                emit_arg(OP_STY, zp);
                expect_write(zp, branch_taken(op, n, v, z, c) ? 8'h00 : 8'h01);
                zp++;
            end
        end
        run_program();
    endtask

    // count down in A, storing each value, until it reaches zero
    task automatic test_branch_loop();
        byte_t count;
        int    i;
        begin_test("branch_loop");
        count = 8'd2 + (rand_byte() & 8'h07);
        emit_arg(OP_LDA, count);
        emit_arg(OP_STA, 8'h60);
        emit(OP_SEC);
        emit_arg(OP_SBC, 8'h01);
        emit_arg(OP_BNE, 8'hF9);
        emit_arg(OP_STA, 8'h61);
        for (i = int'(count); i > 0; i--) begin
            expect_write(8'h60, byte_t'(i));
        end
        expect_write(8'h61, 8'h00);
        run_program();
    endtask

    task automatic test_jump();
        addr_t target;
        byte_t v;
        begin_test("jump");
        v = rand_byte();
        target = RESET_PC + 16'h0100;
        emit_arg(OP_LDA, v);
        emit(OP_JMP);
        emit(target[7:0]);
        emit(target[15:8]);
        // skipped by the jump
        emit_arg(OP_STA, 8'h70);
        emit_pc = target;
        emit_arg(OP_STA, 8'h71);
        expect_write(8'h71, v);
        run_program();
    endtask

    initial begin : main
        reset = 1'b1;
        u_mem.fill_memory();
        begin_test("reset");
        emit(OP_NOP);
        run_program();
        test_load_store();
        test_arith();
        test_logic();
        test_branches();
        test_branch_loop();
        test_jump();
        $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, total_errors);
        if (tests_failed == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // budget grows with every program byte loaded so far
    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (program_bytes == 0 || cycles < 40 * program_bytes) begin
            @(posedge clock);
            cycles++;
        end
        $display("timeout, test %s did not reach its final jump after %0d cycles",
                 test_name, cycles);
        $display(">>> FAIL");
        $finish;
    end

endmodule : tb_core

// File: vlog.f
rtl/core_pkg.sv
rtl/instr_decode.sv
rtl/ucode_sequencer.sv
rtl/alu.sv
rtl/datapath_ctrl.sv
rtl/arch_regs.sv
rtl/core_top.sv
tb/tb_memory.sv
tb/tb_core.sv

// File: run.sh
#!/bin/sh
# build and run the core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module tb_core -o tb_core_sim

output=$(./obj_dir/tb_core_sim)
echo "$output"

# the run counts as passed only if the pass line appears
echo "$output" | grep -q '^>>> PASS$'
